// ==== project.f ====
rtl/aes_pkg.sv
rtl/block_fifo.sv
rtl/axis_block_packer.sv
rtl/aes_whitening_ctrl.sv
rtl/aes_axi_stream_master.sv
rtl/aes_stream_top.sv
test/tb_aes_stream.sv

// ==== rtl/aes_axi_stream_master.sv ====
// AXI-Stream master, buffers whitened blocks and streams them out word by word
`timescale 1ns/1ns

module aes_axi_stream_master
	import aes_pkg::*;
#(
	parameter int out_depth = 8
) (
	input  logic                  m00_axis_aclk,
	input  logic                  rst,
	input  logic                  blk_valid,
	input  block_t                blk_data,
	output logic                  credit_return,
	input  logic                  processing_done,
	output logic                  m00_axis_tvalid,
	output word_t                 m00_axis_tdata,
	output logic [word_s/8-1:0]   m00_axis_tstrb,
	output logic                  m00_axis_tlast,
	input  logic                  m00_axis_tready,
	output logic                  axis_master_done
);

	localparam int wcw = $clog2(nb);

	logic           fifo_rd_valid;
	logic           fifo_empty;
	block_t         fifo_rd_data;
	logic           pop;
	logic           xfer;
	logic           last_word;
	logic           done_seen; // Controller has written the final block
	logic [wcw-1:0] word_cnt;
	block_t         blk_q;

	// Credits keep the controller from overrunning, so wr_ready is not needed
	block_fifo #(
		.payload_t(block_t),
		.depth(out_depth)
	) out_fifo_inst (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.wr_valid(blk_valid),
		.wr_ready(),
		.wr_data(blk_data),
		.rd_valid(fifo_rd_valid),
		.rd_ready(pop),
		.rd_data(fifo_rd_data),
		.full(),
		.empty(fifo_empty)
	);

	assign pop       = fifo_rd_valid && !m00_axis_tvalid; // Only between blocks
	assign xfer      = m00_axis_tvalid && m00_axis_tready;
	assign last_word = (word_cnt == wcw'(nb - 1));

	assign m00_axis_tdata = blk_q[word_cnt*word_s +: word_s]; // Low word first
	assign m00_axis_tstrb = '1;
	assign m00_axis_tlast = m00_axis_tvalid && last_word && done_seen && fifo_empty;

	always_ff @(posedge m00_axis_aclk) begin
		if (rst) begin
			m00_axis_tvalid  <= 1'b0;
			word_cnt         <= '0;
			done_seen        <= 1'b0;
			credit_return    <= 1'b0;
			axis_master_done <= 1'b0;
		end else begin
			credit_return    <= pop; // One credit back per popped block
			axis_master_done <= xfer && m00_axis_tlast;
			if (pop) begin
				m00_axis_tvalid <= 1'b1;
			end else if (xfer && last_word) begin
				m00_axis_tvalid <= 1'b0;
			end
			if (xfer) begin
				word_cnt <= word_cnt + 1'b1;
			end
			// A new frame's flag wins over the clear
			if (processing_done) begin
				done_seen <= 1'b1;
			end else if (xfer && m00_axis_tlast) begin
				done_seen <= 1'b0;
			end
		end
	end

	always_ff @(posedge m00_axis_aclk) begin
		if (pop) begin
			blk_q <= fifo_rd_data;
		end
	end

endmodule

// ==== rtl/aes_pkg.sv ====
// AES stream package with the word and block widths and the shared block types
package aes_pkg;

	parameter int word_s = 32; // Bits per stream word
	parameter int nb     = 4;  // Words per AES block

	typedef logic [word_s-1:0] word_t;

	// Word 0 sits in the low 32 bits
	typedef logic [nb*word_s-1:0] block_t;

	typedef struct packed {
		logic   last; // Final block of a frame
		block_t blk;
	} tagged_block_t;

endpackage

// ==== rtl/aes_stream_top.sv ====
// AES whitening stream top, joins packer, input FIFO, controller and master
`timescale 1ns/1ns

module aes_stream_top
	import aes_pkg::*;
#(
	parameter int in_depth  = 4,
	parameter int out_depth = 8
) (
	input  logic                m00_axis_aclk,
	input  logic                rst,
	input  logic                s_axis_tvalid,
	input  word_t               s_axis_tdata,
	input  logic                s_axis_tlast,
	output logic                s_axis_tready,
	output logic                m00_axis_tvalid,
	output word_t               m00_axis_tdata,
	output logic [word_s/8-1:0] m00_axis_tstrb,
	output logic                m00_axis_tlast,
	input  logic                m00_axis_tready,
	input  block_t              key,
	output logic                axis_master_done
);

	logic          pk_valid;
	logic          pk_ready;
	tagged_block_t pk_data;
	logic          in_valid;
	logic          in_ready;
	tagged_block_t in_data;
	logic          blk_valid;
	block_t        blk_data;
	logic          credit_return;
	logic          processing_done;

	axis_block_packer packer_inst (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tready(s_axis_tready),
		.blk_valid(pk_valid),
		.blk_ready(pk_ready),
		.blk_data(pk_data)
	);

	block_fifo #(
		.payload_t(tagged_block_t),
		.depth(in_depth)
	) in_fifo_inst (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.wr_valid(pk_valid),
		.wr_ready(pk_ready),
		.wr_data(pk_data),
		.rd_valid(in_valid),
		.rd_ready(in_ready),
		.rd_data(in_data),
		.full(),
		.empty()
	);

	aes_whitening_ctrl #(
		.out_depth(out_depth)
	) ctrl_inst (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.key(key),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.blk_valid(blk_valid),
		.blk_data(blk_data),
		.credit_return(credit_return),
		.processing_done(processing_done)
	);

	aes_axi_stream_master #(
		.out_depth(out_depth)
	) master_inst (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.blk_valid(blk_valid),
		.blk_data(blk_data),
		.credit_return(credit_return),
		.processing_done(processing_done),
		.m00_axis_tvalid(m00_axis_tvalid),
		.m00_axis_tdata(m00_axis_tdata),
		.m00_axis_tstrb(m00_axis_tstrb),
		.m00_axis_tlast(m00_axis_tlast),
		.m00_axis_tready(m00_axis_tready),
		.axis_master_done(axis_master_done)
	);

endmodule

// ==== rtl/aes_whitening_ctrl.sv ====
// Whitening controller, XORs each block with the key and forwards it under credits
`timescale 1ns/1ns

module aes_whitening_ctrl
	import aes_pkg::*;
#(
	parameter int out_depth = 8
) (
	input  logic          m00_axis_aclk,
	input  logic          rst,
	input  block_t        key,
	input  logic          in_valid,
	output logic          in_ready,
	input  tagged_block_t in_data,
	output logic          blk_valid,
	output block_t        blk_data,
	input  logic          credit_return,
	output logic          processing_done
);

	localparam int cw = $clog2(out_depth + 1);

	logic [cw-1:0] credit_cnt; // Free slots in the output FIFO
	logic          pop;

	// A credit is spent at the pop, the write follows one cycle later
	assign in_ready = (credit_cnt != '0);
	assign pop      = in_valid && in_ready;

	always_ff @(posedge m00_axis_aclk) begin
		if (rst) begin
			credit_cnt      <= cw'(out_depth);
			blk_valid       <= 1'b0;
			processing_done <= 1'b0;
		end else begin
			credit_cnt      <= credit_cnt + cw'(credit_return) - cw'(pop);
			blk_valid       <= pop;
			processing_done <= pop && in_data.last; // Marks the frame's final block
		end
	end

	// AddRoundKey with the whitening key
	always_ff @(posedge m00_axis_aclk) begin
		if (pop) begin
			blk_data <= in_data.blk ^ key;
		end
	end

endmodule

// ==== rtl/axis_block_packer.sv ====
// AXI-Stream slave that packs four stream words into one tagged AES block
`timescale 1ns/1ns

module axis_block_packer
	import aes_pkg::*;
(
	input  logic          m00_axis_aclk,
	input  logic          rst,
	input  logic          s_axis_tvalid,
	input  word_t         s_axis_tdata,
	input  logic          s_axis_tlast,
	output logic          s_axis_tready,
	output logic          blk_valid,
	input  logic          blk_ready,
	output tagged_block_t blk_data
);

	localparam int wcw = $clog2(nb);

	logic [wcw-1:0] word_cnt;
	logic           pending;  // Full block waiting for the FIFO
	logic           ready_en; // Holds tready low through reset
	logic           beat;
	logic           last_slot;
	tagged_block_t  blk_q;

	assign s_axis_tready = ready_en && (!pending || blk_ready);
	assign beat          = s_axis_tvalid && s_axis_tready;
	assign last_slot     = (word_cnt == wcw'(nb - 1));
	assign blk_valid     = pending;
	assign blk_data      = blk_q;

	always_ff @(posedge m00_axis_aclk) begin
		if (rst) begin
			word_cnt <= '0;
			pending  <= 1'b0;
			ready_en <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			if (pending && blk_ready) begin
				pending <= 1'b0;
			end
			if (beat) begin
				word_cnt <= word_cnt + 1'b1;
				if (last_slot) begin
					pending <= 1'b1; // Fourth word completes the block
				end
			end
		end
	end

	// Old block leaves on the same edge that word 0 of the next one lands
	always_ff @(posedge m00_axis_aclk) begin
		if (beat) begin
			blk_q.blk[word_cnt*word_s +: word_s] <= s_axis_tdata;
			if (last_slot) begin
				blk_q.last <= s_axis_tlast;
			end
		end
	end

endmodule

// ==== rtl/block_fifo.sv ====
// Block FIFO, first-word-fall-through buffer with full and empty flags
`timescale 1ns/1ns

module block_fifo #(
	parameter type payload_t = logic,
	parameter int  depth     = 4
) (
	input  logic     m00_axis_aclk,
	input  logic     rst,
	input  logic     wr_valid,
	output logic     wr_ready,
	input  payload_t wr_data,
	output logic     rd_valid,
	input  logic     rd_ready,
	output payload_t rd_data,
	output logic     full,
	output logic     empty
);

	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);

	payload_t      mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;
	logic          do_wr;
	logic          do_rd;

	// Wrap at depth, which need not be a power of two
	function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
		if (ptr == aw'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full     = (count == cw'(depth));
	assign empty    = (count == '0);
	assign wr_ready = !full || rd_ready; // A pop frees the slot in the same cycle
	assign rd_valid = !empty;
	assign rd_data  = mem[rd_ptr];       // Head entry shown without a read cycle
	assign do_wr    = wr_valid && wr_ready;
	assign do_rd    = rd_valid && rd_ready;

	always_ff @(posedge m00_axis_aclk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge m00_axis_aclk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Idle or push and pop together
			endcase
		end
	end

endmodule

// ==== test/tb_aes_stream.sv ====
// Testbench for the AES whitening stream, random frames checked against a reference model
`timescale 1ns/1ns

module tb_aes_stream
	import aes_pkg::*;
;

	localparam int in_depth  = 4;
	localparam int out_depth = 8;

	typedef struct packed {
		logic [nb-1:0] last; // Expected tlast per word
		block_t        words;
	} expect_t;

	logic                m00_axis_aclk = 1'b0;
	logic                rst;
	logic                s_axis_tvalid;
	word_t               s_axis_tdata;
	logic                s_axis_tlast;
	logic                s_axis_tready;
	logic                m00_axis_tvalid;
	word_t               m00_axis_tdata;
	logic [word_s/8-1:0] m00_axis_tstrb;
	logic                m00_axis_tlast;
	logic                m00_axis_tready;
	block_t              key;
	logic                axis_master_done;

	word_t exp_words[$];
	logic  exp_lasts[$];
	int    rnd;
	int    cycles      = 0;
	int    sent_words  = 0;
	int    out_words   = 0;
	int    frame_cnt   = 0;
	int    done_cnt    = 0;
	int    hold_beats  = 0;
	logic  rand_ready  = 1'b0;
	logic  hold_sink   = 1'b0;
	logic  stall_seen  = 1'b0;
	logic  rst_d       = 1'b1;
	logic  prev_stall  = 1'b0;
	word_t prev_data;
	logic  prev_last;
	logic  tlast_xfer_d = 1'b0; // Tlast beat seen at the previous edge

	aes_stream_top #(
		.in_depth(in_depth),
		.out_depth(out_depth)
	) aes_stream_top_inst (
		.m00_axis_aclk(m00_axis_aclk),
		.rst(rst),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tready(s_axis_tready),
		.m00_axis_tvalid(m00_axis_tvalid),
		.m00_axis_tdata(m00_axis_tdata),
		.m00_axis_tstrb(m00_axis_tstrb),
		.m00_axis_tlast(m00_axis_tlast),
		.m00_axis_tready(m00_axis_tready),
		.key(key),
		.axis_master_done(axis_master_done)
	);

	initial begin
		forever #4 m00_axis_aclk = ~m00_axis_aclk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	// AddRoundKey per word, word 0 first, tlast only on the frame's final word
	function automatic expect_t whiten_ref(input block_t blk, input block_t k,
		input logic frame_end);
		expect_t e;
		for (int i = 0; i < nb; i++) begin
			e.words[i*word_s +: word_s] = blk[i*word_s +: word_s] ^ k[i*word_s +: word_s];
			e.last[i] = frame_end && (i == nb - 1);
		end
		return e;
	endfunction

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t: %s tdata got %h expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_last(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t: %s tlast got %b expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_strb(input logic [word_s/8-1:0] got, input logic [word_s/8-1:0] exp,
		input string what);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t: %s tstrb got %b expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_done(input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %0t: axis_master_done got %b expected %b", $time, got, exp));
		end
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic send_word(input word_t w, input logic l, input logic gaps);
		s_axis_tvalid = 1'b1;
		s_axis_tdata  = w;
		s_axis_tlast  = l;
		@(posedge m00_axis_aclk);
		while (!s_axis_tready) @(posedge m00_axis_aclk);
		sent_words++;
		@(negedge m00_axis_aclk);
		s_axis_tvalid = 1'b0;
		if (gaps) begin
			repeat ($urandom % 3) @(negedge m00_axis_aclk);
		end
	endtask

	task automatic send_frame(input int nblocks, input logic gaps);
		block_t  blk;
		expect_t e;
		frame_cnt++;
		for (int b = 0; b < nblocks; b++) begin
			blk = {$urandom, $urandom, $urandom, $urandom};
			e   = whiten_ref(blk, key, b == nblocks - 1);
			for (int i = 0; i < nb; i++) begin
				exp_words.push_back(e.words[i*word_s +: word_s]);
				exp_lasts.push_back(e.last[i]);
			end
			for (int i = 0; i < nb; i++) begin
				send_word(blk[i*word_s +: word_s], (b == nblocks - 1) && (i == nb - 1), gaps);
			end
		end
	endtask

	task automatic wait_frames();
		while (done_cnt < frame_cnt) @(negedge m00_axis_aclk);
	endtask

	// Stalls the sink mid-frame and checks how far the slave side gets
	task automatic hold_sequence();
		int start;
		start = out_words;
		while (out_words < start + 8) @(negedge m00_axis_aclk);
		hold_beats = 0;
		stall_seen = 1'b0;
		hold_sink  <= 1'b1;
		repeat (100) @(negedge m00_axis_aclk);
		if (!stall_seen) begin
			abort_run("s_axis_tready never fell while the sink was held not ready");
		end
		if (hold_beats > (in_depth + out_depth + 3) * nb) begin
			abort_run($sformatf("ERR %0t: %0d words accepted while the sink was held",
				$time, hold_beats));
		end
		hold_sink <= 1'b0;
	endtask

	always @(negedge m00_axis_aclk) begin
		if (hold_sink) begin
			m00_axis_tready = 1'b0;
		end else if (rand_ready) begin
			m00_axis_tready = 1'($urandom % 2); // 50 % ready
		end else begin
			m00_axis_tready = 1'b1;
		end
	end

	always @(posedge m00_axis_aclk) begin
		cycles++;
		if (cycles > 40 * sent_words + 200) begin
			abort_run($sformatf("Timeout after %0d cycles with %0d words sent",
				cycles, sent_words));
		end
	end

	// Output monitor
	always @(posedge m00_axis_aclk) begin
		if (rst || rst_d) begin
			if (m00_axis_tvalid || m00_axis_tlast || axis_master_done) begin
				abort_run($sformatf("ERR %0t: output active during or just after reset", $time));
			end
		end else begin
			check_done(axis_master_done, tlast_xfer_d);
			if (axis_master_done) begin
				done_cnt++;
			end
			if (prev_stall) begin
				if (!m00_axis_tvalid) begin
					abort_run($sformatf("ERR %0t: tvalid dropped before the beat transferred",
						$time));
				end
				check_word(m00_axis_tdata, prev_data, "Stalled beat");
				check_last(m00_axis_tlast, prev_last, "Stalled beat");
			end
			if (m00_axis_tvalid && m00_axis_tready) begin
				if (exp_words.size() == 0) begin
					abort_run($sformatf("ERR %0t: output beat with no word expected", $time));
				end
				check_word(m00_axis_tdata, exp_words.pop_front(), "Output");
				check_last(m00_axis_tlast, exp_lasts.pop_front(), "Output");
				check_strb(m00_axis_tstrb, '1, "Output");
				out_words++;
			end
			if (hold_sink && s_axis_tvalid) begin
				if (s_axis_tready) begin
					hold_beats++;
				end else begin
					stall_seen = 1'b1;
				end
			end
		end
		prev_stall   = m00_axis_tvalid && !m00_axis_tready;
		prev_data    = m00_axis_tdata;
		prev_last    = m00_axis_tlast;
		tlast_xfer_d = m00_axis_tvalid && m00_axis_tready && m00_axis_tlast;
		rst_d        = rst;
	end

	initial begin
		rnd           = $urandom(95635);
		rst           = 1'b1;
		s_axis_tvalid = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tlast  = 1'b0;
		m00_axis_tready = 1'b0;
		key           = '0;
		repeat (2) @(negedge m00_axis_aclk);
		rst = 1'b0;
		@(negedge m00_axis_aclk);

		// One block, fixed key
		key = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;
		send_frame(1, 1'b0);
		wait_frames();

		// Five frames of random length under one random key
		key = {$urandom, $urandom, $urandom, $urandom};
		for (int f = 0; f < 5; f++) begin
			send_frame(1 + $urandom % 6, 1'b0);
			wait_frames();
		end

		// Random sink ready and source gaps
		rand_ready <= 1'b1;
		key = {$urandom, $urandom, $urandom, $urandom};
		for (int f = 0; f < 4; f++) begin
			send_frame(1 + $urandom % 6, 1'b1);
			wait_frames();
		end
		rand_ready <= 1'b0;

		// Long frame with the sink held
		key = {$urandom, $urandom, $urandom, $urandom};
		fork
			send_frame(24, 1'b0);
			hold_sequence();
		join
		wait_frames();

		repeat (5) @(negedge m00_axis_aclk);
		if (exp_words.size() != 0 || done_cnt != frame_cnt) begin
			abort_run($sformatf("%0d words still expected, %0d of %0d frames done",
				exp_words.size(), done_cnt, frame_cnt));
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule
